/* files.f */
source/fpMulPkg.sv
source/signExpPath.sv
source/mantissaPath.sv
source/laneOutputStage.sv
source/fpMulInputStage.sv
sim/clockGen.sv
sim/tbFpMulInput.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timing -f files.f --top-module tbFpMulInput -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Verification failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Verification passed" sim.log || { echo "simulation FAILED, no result in log"; exit 1; }
echo "simulation PASSED"
exit 0

/* sim/tbFpMulInput.sv */
`timescale 1ns/1ps

module tbFpMulInput
    import fpMulPkg::*;
();

    localparam int          N_TESTS   = 5;
    localparam int          ITEMS     = 40;
    localparam int          WATCHDOG  = N_TESTS * ITEMS * 4 + 20;   // in clock cycles
    localparam int          WORD_W    = LANES + LANES * EXPSUM_W + 2 * LANES * SLICE_W + 2;
    localparam logic [31:0] SEED      = 32'h7e7b;
    localparam int          T_FP16    = 0;
    localparam int          T_FP32    = 1;
    localparam int          T_CLEAR   = 2;
    localparam int          T_MIXED   = 3;

    logic                           clk;
    logic                           rstn;
    logic                           i_valid;
    logic                           o_inReady;
    logic [OP_W-1:0]                i_opA;
    logic [OP_W-1:0]                i_opB;
    logic [1:0]                     i_mode;
    logic                           o_valid;
    logic                           i_outReady;
    logic [LANES-1:0]               o_sign;
    logic [LANES-1:0][EXPSUM_W-1:0] o_exp;
    logic [LANES-1:0][SLICE_W-1:0]  o_manA;
    logic [LANES-1:0][SLICE_W-1:0]  o_manB;
    logic [1:0]                     o_mode;

    logic [WORD_W-1:0]              dutWord;
    logic [WORD_W-1:0]              expQ[$];         // expected words, oldest first
    logic [WORD_W-1:0]              expHead = '0;
    logic                           headValid = 1'b0;
    logic                           inXfer = 1'b0;   // acceptance on the last rising edge
    logic                           seenInput = 1'b0;
    logic                           stallOn;
    logic [31:0]                    rngState;
    int                             errCount;
    int                             sentCount;
    int                             checkedCount;

    clockGen #(.PERIOD(40), .RESET_CYCLES(2)) uClock (
        .clk  (clk),
        .rstn (rstn)
    );

    fpMulInputStage UUT (
        .clk        (clk),
        .rstn       (rstn),
        .i_valid    (i_valid),
        .o_inReady  (o_inReady),
        .i_opA      (i_opA),
        .i_opB      (i_opB),
        .i_mode     (i_mode),
        .o_valid    (o_valid),
        .i_outReady (i_outReady),
        .o_sign     (o_sign),
        .o_exp      (o_exp),
        .o_manA     (o_manA),
        .o_manB     (o_manB),
        .o_mode     (o_mode)
    );

    assign dutWord = {o_sign, o_exp, o_manA, o_manB, o_mode};

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // random word with some lanes forced to a signed zero
    function automatic logic [OP_W-1:0] makeOperand(input logic [1:0] mode);
        logic [OP_W-1:0] w;
        logic [31:0]     r;
        for (int k = 0; k < OP_W / 32; k++) begin
            w[32*k +: 32] = nextRand();
        end
        r = nextRand();
        if (mode == MODE_FP32) begin
            for (int n = 0; n < 4; n++) begin
                if (r[3*n +: 3] == 3'd0) w[32*n +: 31] = '0;   // keep the sign bit
            end
        end else begin
            for (int l = 0; l < 16; l++) begin
                if (r[2*l +: 2] == 2'd0) w[16*l +: 15] = '0;
            end
        end
        return w;
    endfunction

    // expected output word built lane by lane from the format rules
    function automatic logic [WORD_W-1:0] refModel(input logic [OP_W-1:0] a,
                                                   input logic [OP_W-1:0] b,
                                                   input logic [1:0] mode);
        logic [15:0]       sgn;
        logic [15:0][9:0]  ex;
        logic [15:0][12:0] ma;
        logic [15:0][12:0] mb;
        logic [15:0]       ha;
        logic [15:0]       hb;
        logic [31:0]       sa;
        logic [31:0]       sb;
        logic [12:0]       hiA;
        logic [12:0]       hiB;
        logic [9:0]        ofs;
        int                l;
        sgn = '0;
        ex  = '0;
        ma  = '0;
        mb  = '0;
        if (mode == 2'b00) begin
            for (int n = 0; n < 16; n++) begin
                ha = a[16*n +: 16];
                hb = b[16*n +: 16];
                ma[n] = {2'b00, |ha[14:10], ha[9:0]};
                mb[n] = {2'b00, |hb[14:10], hb[9:0]};
                if (ha[14:0] != 15'd0 && hb[14:0] != 15'd0) begin
                    sgn[n] = ha[15] ^ hb[15];
                    ex[n]  = 10'(ha[14:10]) + 10'(hb[14:10]);
                end
            end
        end else if (mode == 2'b01) begin
            for (int n = 0; n < 4; n++) begin
                sa  = a[32*n +: 32];
                sb  = b[32*n +: 32];
                hiA = {2'b00, |sa[30:23], sa[22:13]};
                hiB = {2'b00, |sb[30:23], sb[22:13]};
                for (int k = 0; k < 4; k++) begin
                    l     = 4 * n + k;
                    ofs   = (k == 0) ? 10'd26 : (k == 3) ? 10'd0 : 10'd13;
                    ma[l] = (k < 2) ? hiA : sa[12:0];
                    mb[l] = (k == 0 || k == 2) ? hiB : sb[12:0];
                    if (sa[30:0] != 31'd0 && sb[30:0] != 31'd0) begin
                        sgn[l] = sa[31] ^ sb[31];
                        ex[l]  = 10'(sa[30:23]) + 10'(sb[30:23]) + ofs;
                    end
                end
            end
        end
        return {sgn, ex, ma, mb, mode};
    endfunction

    function automatic logic [1:0] pickMode(input int kind, input int idx);
        case (kind)
            T_FP16:  return MODE_FP16;
            T_FP32:  return MODE_FP32;
            T_CLEAR: return idx[0] ? MODE_RSVD : MODE_ZERO;
            default: return 2'(nextRand());
        endcase
    endfunction

    task automatic driveReady();
        if (stallOn) begin
            i_outReady = (nextRand() % 8) >= 3;   // low about 3 cycles in 8
        end else begin
            i_outReady = 1'b1;
        end
    endtask

    // hold the item until the DUT takes it
    task automatic sendItem(input logic [1:0] mode);
        i_valid = 1'b1;
        i_mode  = mode;
        i_opA   = makeOperand(mode);
        i_opB   = makeOperand(mode);
        driveReady();
        @(negedge clk);
        while (!inXfer) begin
            driveReady();
            @(negedge clk);
        end
        sentCount++;
    endtask

    task automatic drainOutputs();
        i_valid = 1'b0;
        while (expQ.size() != 0) begin
            driveReady();
            @(negedge clk);
        end
        i_outReady = 1'b1;
    endtask

    task automatic runStream(input string name, input int kind, input logic stall);
        int errStart;
        errStart = errCount;
        stallOn  = stall;
        for (int n = 0; n < ITEMS; n++) begin
            sendItem(pickMode(kind, n));
        end
        drainOutputs();
        stallOn = 1'b0;
        $display("test %s done: %0d items, %0d errors", name, ITEMS, errCount - errStart);
    endtask

    // scoreboard bookkeeping on the rising edge
    always @(posedge clk) begin
        if (!rstn) begin
            inXfer <= 1'b0;
        end else begin
            inXfer <= i_valid && o_inReady;
            if (o_valid && i_outReady) begin
                checkedCount++;
                if (expQ.size() != 0) void'(expQ.pop_front());
            end
            if (i_valid && o_inReady) begin
                expQ.push_back(refModel(i_opA, i_opB, i_mode));
                seenInput <= 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        headValid = (expQ.size() != 0);
        if (headValid) expHead = expQ[0];
    end

    aResetState: assert property (@(posedge clk) disable iff (!rstn)
        !seenInput |-> !o_valid && o_mode == MODE_ZERO)
        else begin
            errCount++;
            $display("ERR %0t: output not idle after reset", $time);
        end

    aOutMatch: assert property (@(posedge clk) disable iff (!rstn)
        o_valid && i_outReady |-> headValid && dutWord == expHead)
        else begin
            errCount++;
            $display("ERR %0t: output word mismatch, got %h expected %h",
                     $time, $sampled(dutWord), $sampled(expHead));
        end

    aStallHold: assert property (@(posedge clk) disable iff (!rstn)
        o_valid && !i_outReady |=> o_valid && $stable(dutWord))
        else begin
            errCount++;
            $display("ERR %0t: output changed or dropped while stalled", $time);
        end

    // ready unless a held item is stalled
    aReadyRule: assert property (@(posedge clk) disable iff (!rstn)
        o_inReady == !(o_valid && !i_outReady))
        else begin
            errCount++;
            $display("ERR %0t: o_inReady is %b with o_valid %b and i_outReady %b",
                     $time, $sampled(o_inReady), $sampled(o_valid), $sampled(i_outReady));
        end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles, DUT stopped handshaking", WATCHDOG);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int errStart;
        i_valid      = 1'b0;
        i_opA        = '0;
        i_opB        = '0;
        i_mode       = MODE_ZERO;
        i_outReady   = 1'b1;
        stallOn      = 1'b0;
        rngState     = SEED;
        errCount     = 0;
        sentCount    = 0;
        checkedCount = 0;

        @(posedge rstn);
        @(negedge clk);
        errStart = errCount;
        repeat (3) @(negedge clk);            // idle edges reach the reset check
        $display("test reset done: 0 items, %0d errors", errCount - errStart);

        runStream("fp16", T_FP16, 1'b0);
        runStream("fp32", T_FP32, 1'b0);
        runStream("zero/reserved", T_CLEAR, 1'b0);
        runStream("back-pressure", T_MIXED, 1'b1);

        assert (expQ.size() == 0 && checkedCount == sentCount)
        else begin
            errCount++;
            $display("accepted items did not all come out: sent %0d, received %0d",
                     sentCount, checkedCount);
        end

        $display("tests %0d, items sent %0d, items checked %0d, errors %0d",
                 N_TESTS, sentCount, checkedCount, errCount);
        if (errCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* sim/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lands on a falling edge, clear of the rising edge
    initial begin
        rstn = 1'b0;
        #(PERIOD * RESET_CYCLES) rstn = 1'b1;
    end

endmodule

/* source/fpMulInputStage.sv */
`timescale 1ns/1ps

module fpMulInputStage
    import fpMulPkg::*;
(
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           i_valid,
    output logic                           o_inReady,
    input  logic [OP_W-1:0]                i_opA,
    input  logic [OP_W-1:0]                i_opB,
    input  logic [1:0]                     i_mode,
    output logic                           o_valid,
    input  logic                           i_outReady,
    output logic [LANES-1:0]               o_sign,
    output logic [LANES-1:0][EXPSUM_W-1:0] o_exp,
    output logic [LANES-1:0][SLICE_W-1:0]  o_manA,
    output logic [LANES-1:0][SLICE_W-1:0]  o_manB,
    output logic [1:0]                     o_mode
);

    // combinational results ahead of the register
    logic [LANES-1:0]               laneSign;
    logic [LANES-1:0][EXPSUM_W-1:0] laneExp;
    logic [LANES-1:0]               laneZero;
    logic [LANES-1:0][SLICE_W-1:0]  laneManA;
    logic [LANES-1:0][SLICE_W-1:0]  laneManB;

    signExpPath uSignExp (
        .i_opA  (i_opA),
        .i_opB  (i_opB),
        .i_mode (i_mode),
        .o_sign (laneSign),
        .o_exp  (laneExp),
        .o_zero (laneZero)
    );

    mantissaPath uMantissa (
        .i_opA  (i_opA),
        .i_opB  (i_opB),
        .i_mode (i_mode),
        .o_manA (laneManA),
        .o_manB (laneManB)
    );

    // masking plus the single handshake register
    laneOutputStage uOutStage (
        .clk        (clk),
        .rstn       (rstn),
        .i_valid    (i_valid),
        .o_inReady  (o_inReady),
        .i_outReady (i_outReady),
        .o_valid    (o_valid),
        .i_mode     (i_mode),
        .i_sign     (laneSign),
        .i_exp      (laneExp),
        .i_zero     (laneZero),
        .i_manA     (laneManA),
        .i_manB     (laneManB),
        .o_sign     (o_sign),
        .o_exp      (o_exp),
        .o_manA     (o_manA),
        .o_manB     (o_manB),
        .o_mode     (o_mode)
    );

endmodule

/* source/laneOutputStage.sv */
`timescale 1ns/1ps

module laneOutputStage
    import fpMulPkg::*;
(
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_valid,
    output logic                          o_inReady,
    input  logic                          i_outReady,
    output logic                          o_valid,
    input  logic [1:0]                    i_mode,
    input  logic [LANES-1:0]              i_sign,
    input  logic [LANES-1:0][EXPSUM_W-1:0] i_exp,
    input  logic [LANES-1:0]              i_zero,
    input  logic [LANES-1:0][SLICE_W-1:0] i_manA,
    input  logic [LANES-1:0][SLICE_W-1:0] i_manB,
    output logic [LANES-1:0]              o_sign,
    output logic [LANES-1:0][EXPSUM_W-1:0] o_exp,
    output logic [LANES-1:0][SLICE_W-1:0] o_manA,
    output logic [LANES-1:0][SLICE_W-1:0] o_manB,
    output logic [1:0]                    o_mode
);

    logic                           clearAll;
    logic                           load;
    logic [LANES-1:0]               nextSign;
    logic [LANES-1:0][EXPSUM_W-1:0] nextExp;
    logic [LANES-1:0][SLICE_W-1:0]  nextManA;
    logic [LANES-1:0][SLICE_W-1:0]  nextManB;

    assign clearAll  = (i_mode == MODE_ZERO) || (i_mode == MODE_RSVD);
    assign o_inReady = !o_valid || i_outReady;     // empty or draining this edge
    assign load      = i_valid && o_inReady;

    always_comb begin
        nextManA = clearAll ? '0 : i_manA;
        nextManB = clearAll ? '0 : i_manB;
        for (int l = 0; l < LANES; l++) begin
            // zero operand in this lane kills sign and exponent only
            nextSign[l] = (clearAll || i_zero[l]) ? 1'b0 : i_sign[l];
            nextExp[l]  = (clearAll || i_zero[l]) ? '0 : i_exp[l];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_valid <= 1'b0;
            o_mode  <= MODE_ZERO;
        end else if (o_inReady) begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_mode <= i_mode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_sign <= nextSign;
            o_exp  <= nextExp;
            o_manA <= nextManA;
            o_manB <= nextManB;
        end
    end

    // a stalled item must not change under the consumer
    aHoldStable: assert property (@(posedge clk) disable iff (!rstn)
        o_valid && !i_outReady |=> $stable(o_sign) && $stable(o_exp) &&
                                   $stable(o_manA) && $stable(o_manB) && $stable(o_mode))
        else $error("laneOutputStage: output changed while stalled");

    aNoDrop: assert property (@(posedge clk) disable iff (!rstn)
        o_valid && !i_outReady |=> o_valid)
        else $error("laneOutputStage: valid dropped without a transfer");

endmodule

/* source/mantissaPath.sv */
`timescale 1ns/1ps

module mantissaPath
    import fpMulPkg::*;
(
    input  operandWord_t                  i_opA,
    input  operandWord_t                  i_opB,
    input  logic [1:0]                    i_mode,
    output logic [LANES-1:0][SLICE_W-1:0] o_manA,
    output logic [LANES-1:0][SLICE_W-1:0] o_manB
);

    // hidden bits, set for any nonzero exponent
    logic [LANES-1:0]                    hidA16;
    logic [LANES-1:0]                    hidB16;
    logic [FP32_LANES-1:0]               hidA32;
    logic [FP32_LANES-1:0]               hidB32;

    // per-format slices
    logic [LANES-1:0][SLICE_W-1:0]       halfA;
    logic [LANES-1:0][SLICE_W-1:0]       halfB;
    logic [FP32_LANES-1:0][SLICE_W-1:0]  hiA;
    logic [FP32_LANES-1:0][SLICE_W-1:0]  loA;
    logic [FP32_LANES-1:0][SLICE_W-1:0]  hiB;
    logic [FP32_LANES-1:0][SLICE_W-1:0]  loB;

    for (genvar i = 0; i < LANES; i++) begin : gHalf
        assign hidA16[i] = |i_opA.half[i][MAN16_W +: EXP16_W];   // each lane its own bit
        assign hidB16[i] = |i_opB.half[i][MAN16_W +: EXP16_W];
        assign halfA[i]  = SLICE_W'({hidA16[i], i_opA.half[i][MAN16_W-1:0]});
        assign halfB[i]  = SLICE_W'({hidB16[i], i_opB.half[i][MAN16_W-1:0]});
    end

    for (genvar j = 0; j < FP32_LANES; j++) begin : gSingle
        assign hidA32[j] = |i_opA.single[j][MAN32_W +: EXP32_W];
        assign hidB32[j] = |i_opB.single[j][MAN32_W +: EXP32_W];
        // high slice is hidden bit over fraction 22..13, low slice is 12..0
        assign hiA[j]    = SLICE_W'({hidA32[j], i_opA.single[j][MAN32_W-1:SLICE_W]});
        assign hiB[j]    = SLICE_W'({hidB32[j], i_opB.single[j][MAN32_W-1:SLICE_W]});
        assign loA[j]    = i_opA.single[j][SLICE_W-1:0];
        assign loB[j]    = i_opB.single[j][SLICE_W-1:0];
    end

    always_comb begin
        o_manA = '0;
        o_manB = '0;
        case (i_mode)
            MODE_FP16: begin
                o_manA = halfA;
                o_manB = halfB;
            end
            MODE_FP32: begin
                for (int s = 0; s < LANES; s++) begin
                    // a: hi hi lo lo, b: hi lo hi lo
                    o_manA[s] = (s % SUB_PER_LANE < 2) ? hiA[s / SUB_PER_LANE]
                                                       : loA[s / SUB_PER_LANE];
                    o_manB[s] = (s % 2 == 0) ? hiB[s / SUB_PER_LANE]
                                             : loB[s / SUB_PER_LANE];
                end
            end
            default: begin
                // no slices outside the two live formats
            end
        endcase
    end

    // an unknown mode would select garbage in both paths at once
    aModeKnown: assert property (@(i_mode) !$isunknown(i_mode))
        else $error("mantissaPath: mode select has unknown bits");

endmodule

/* source/signExpPath.sv */
`timescale 1ns/1ps

module signExpPath
    import fpMulPkg::*;
(
    input  operandWord_t                   i_opA,
    input  operandWord_t                   i_opB,
    input  logic [1:0]                     i_mode,
    output logic [LANES-1:0]               o_sign,
    output logic [LANES-1:0][EXPSUM_W-1:0] o_exp,
    output logic [LANES-1:0]               o_zero
);

    // fp16 lane results
    logic [LANES-1:0]                     zeroA16;
    logic [LANES-1:0]                     zeroB16;
    logic [LANES-1:0]                     sign16;
    logic [LANES-1:0][EXPSUM_W-1:0]       exp16;

    // fp32 lane results, before the sub-lane offset
    logic [FP32_LANES-1:0]                zeroA32;
    logic [FP32_LANES-1:0]                zeroB32;
    logic [FP32_LANES-1:0]                sign32;
    logic [FP32_LANES-1:0][EXPSUM_W-1:0]  exp32;

    // shift offset of sub-lane k within one fp32 product
    function automatic logic [EXPSUM_W-1:0] subOffset(input int k);
        case (k)
            0:       return OFS_HH;
            1, 2:    return OFS_HL;
            default: return OFS_LL;
        endcase
    endfunction

    for (genvar i = 0; i < LANES; i++) begin : gHalf
        assign zeroA16[i] = (i_opA.half[i][MAN16_W +: EXP16_W] == '0) &&
                            (i_opA.half[i][MAN16_W-1:0] == '0);
        assign zeroB16[i] = (i_opB.half[i][MAN16_W +: EXP16_W] == '0) &&
                            (i_opB.half[i][MAN16_W-1:0] == '0);
        assign sign16[i]  = i_opA.half[i][HALF_W-1] ^ i_opB.half[i][HALF_W-1];
        assign exp16[i]   = EXPSUM_W'(i_opA.half[i][MAN16_W +: EXP16_W]) +
                            EXPSUM_W'(i_opB.half[i][MAN16_W +: EXP16_W]);
    end

    for (genvar j = 0; j < FP32_LANES; j++) begin : gSingle
        assign zeroA32[j] = (i_opA.single[j][MAN32_W +: EXP32_W] == '0) &&
                            (i_opA.single[j][MAN32_W-1:0] == '0);
        assign zeroB32[j] = (i_opB.single[j][MAN32_W +: EXP32_W] == '0) &&
                            (i_opB.single[j][MAN32_W-1:0] == '0);
        assign sign32[j]  = i_opA.single[j][SINGLE_W-1] ^ i_opB.single[j][SINGLE_W-1];
        assign exp32[j]   = EXPSUM_W'(i_opA.single[j][MAN32_W +: EXP32_W]) +
                            EXPSUM_W'(i_opB.single[j][MAN32_W +: EXP32_W]); // biases kept
    end

    always_comb begin
        o_sign = '0;
        o_exp  = '0;
        o_zero = '0;
        case (i_mode)
            MODE_FP16: begin
                o_sign = sign16;
                o_exp  = exp16;
                o_zero = zeroA16 | zeroB16;
            end
            MODE_FP32: begin
                // four sub-lanes per product, ordered hh, hl, lh, ll
                for (int s = 0; s < LANES; s++) begin
                    o_sign[s] = sign32[s / SUB_PER_LANE];
                    o_exp[s]  = exp32[s / SUB_PER_LANE] + subOffset(s % SUB_PER_LANE);
                    o_zero[s] = zeroA32[s / SUB_PER_LANE] | zeroB32[s / SUB_PER_LANE];
                end
            end
            default: begin
                // reserved and zero modes, cleared downstream anyway
            end
        endcase
    end

endmodule

/* source/fpMulPkg.sv */
package fpMulPkg;

    // operand word and lane counts
    localparam int OP_W       = 256;
    localparam int LANES      = 16;   // 13-bit sub-lanes of the multiplier array
    localparam int FP32_LANES = 4;    // only the low 128 bits carry fp32 lanes

    // half precision fields
    localparam int EXP16_W = 5;
    localparam int MAN16_W = 10;
    localparam int HALF_W  = 1 + EXP16_W + MAN16_W;

    // single precision fields
    localparam int EXP32_W  = 8;
    localparam int MAN32_W  = 23;
    localparam int SINGLE_W = 1 + EXP32_W + MAN32_W;

    // output widths
    localparam int SLICE_W  = 13;     // one mantissa slice per sub-lane
    localparam int EXPSUM_W = 10;     // exp sum plus offset, no overflow

    // each fp32 product is spread over this many sub-lanes
    localparam int SUB_PER_LANE = LANES / FP32_LANES;

    // word views
    localparam int HALF_SLOTS   = OP_W / HALF_W;
    localparam int SINGLE_SLOTS = OP_W / SINGLE_W;

    // exponent offset of each partial product, in bits of shift
    localparam logic [EXPSUM_W-1:0] OFS_HH = 10'd26;  // high x high
    localparam logic [EXPSUM_W-1:0] OFS_HL = 10'd13;  // cross terms
    localparam logic [EXPSUM_W-1:0] OFS_LL = 10'd0;   // low x low

    // format select
    localparam logic [1:0] MODE_FP16 = 2'b00;
    localparam logic [1:0] MODE_FP32 = 2'b01;
    localparam logic [1:0] MODE_RSVD = 2'b10;   // former fp64 code
    localparam logic [1:0] MODE_ZERO = 2'b11;

    // one operand word, read as halves or as singles depending on mode
    typedef union packed {
        logic [HALF_SLOTS-1:0][HALF_W-1:0]     half;
        logic [SINGLE_SLOTS-1:0][SINGLE_W-1:0] single;
    } operandWord_t;

endpackage
